// ==== list.f ====
common/codec_pkg.sv
source/enc_8b10b.sv
source/dec_8b10b.sv
source/link_regs.sv
source/codec_top.sv
bench/tb_codec.sv

// ==== Bender.yml ====
package:
  name: codec_8b10b

sources:
  - common/codec_pkg.sv
  - source/enc_8b10b.sv
  - source/dec_8b10b.sv
  - source/link_regs.sv
  - source/codec_top.sv
  - target: test
    files:
      - bench/tb_codec.sv

// ==== bench/tb_codec.sv ====
// 8b/10b codec testbench
module tb_codec;
    timeunit 1ns;
    timeprecision 1ps;

    // ====================
    // Run lengths
    // ====================
    localparam int RESET_CYCLES = 16;
    localparam int N_BYTES = 400;
    localparam int N_CODE_ERR = 20;
    localparam int N_DISP_PAIRS = 10;
    localparam int N_OFF = 40;
    localparam int N_RESUME = 50;
    // Setup, access and one idle cycle per APB transfer
    localparam int APB_CYCLES = 3;
    // Traffic runs at 3/4 duty, so twice the byte count bounds a traffic phase
    localparam int LEN_ENCODE = 2 * N_BYTES + 3 * APB_CYCLES;
    localparam int LEN_ERRORS = N_CODE_ERR + 3 * N_DISP_PAIRS + 2 + 3 * APB_CYCLES;
    localparam int LEN_REGS = 14 * APB_CYCLES + N_OFF + 2 * N_RESUME;
    localparam int TIMEOUT_CYCLES = 2 * (LEN_ENCODE + LEN_ERRORS + LEN_REGS) + RESET_CYCLES;

    // Standard 5b/6b codes abcdei at negative disparity, D.0 to D.31
    localparam logic [5:0] SUB6 [32] = '{
        6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
        6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
        6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
        6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
    };
    // Standard 3b/4b codes fghj at negative disparity, primary forms
    localparam logic [3:0] SUB4 [8] = '{
        4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
    };
    // The twelve control characters
    localparam codec_pkg::byte_t K_LIST [12] = '{
        8'h1C, 8'h3C, 8'h5C, 8'h7C, 8'h9C, 8'hBC, 8'hDC, 8'hFC, 8'hF7, 8'hFB, 8'hFD, 8'hFE
    };
    localparam codec_pkg::symbol_t K28_5_NEG = 10'b0011111010;
    localparam codec_pkg::symbol_t K28_5_POS = 10'b1100000101;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    codec_pkg::apb_addr_t paddr;
    codec_pkg::apb_data_t pwdata;
    codec_pkg::apb_data_t prdata;
    logic                 pready;
    logic                 pslverr;
    codec_pkg::byte_t     tx_data;
    logic                 tx_k;
    logic                 tx_valid;
    codec_pkg::symbol_t   tx_symbol;
    logic                 tx_symbol_valid;
    codec_pkg::symbol_t   rx_symbol;
    logic                 rx_valid;
    codec_pkg::byte_t     rx_data;
    logic                 rx_k;
    logic                 rx_disperr;
    logic                 rx_notintable;
    logic                 rx_data_valid;

    // Loopback or direct symbol injection on the receive side
    logic                 loopback;
    codec_pkg::symbol_t   inj_symbol;
    logic                 inj_valid;
    logic [31:0]          lcg_state = 32'd45;
    // Model running disparity of the encoder
    logic                 model_rd;
    // Expected decoded bytes with the K flag on top
    logic [8:0]           exp_q [$];
    int                   cycle_count = 0;

    assign rx_symbol = loopback ? tx_symbol : inj_symbol;
    assign rx_valid = loopback ? tx_symbol_valid : inj_valid;

    codec_top #(
        .ERR_CNT_W(16)
    ) u_codec_top (
        .clk            (clk),
        .reset          (reset),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .tx_data        (tx_data),
        .tx_k           (tx_k),
        .tx_valid       (tx_valid),
        .tx_symbol      (tx_symbol),
        .tx_symbol_valid(tx_symbol_valid),
        .rx_symbol      (rx_symbol),
        .rx_valid       (rx_valid),
        .rx_data        (rx_data),
        .rx_k           (rx_k),
        .rx_disperr     (rx_disperr),
        .rx_notintable  (rx_notintable),
        .rx_data_valid  (rx_data_valid)
    );

    always #5 clk = ~clk;

    // Hard limit on the whole run
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("Timeout: the run did not finish in %0d cycles",
                TIMEOUT_CYCLES));
        end
    end

    // ====================
    // Checks
    // ====================
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_symbol(input string what, input codec_pkg::symbol_t got,
                                input codec_pkg::symbol_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("** Error at %0t: %s is %b, expected %b",
                $time, what, got, exp));
        end
    endtask

    task automatic check_byte(input string what, input codec_pkg::byte_t got,
                              input codec_pkg::byte_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("** Error at %0t: %s is %h, expected %h",
                $time, what, got, exp));
        end
    endtask

    task automatic check_count(input string what, input codec_pkg::apb_data_t got,
                               input codec_pkg::apb_data_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("** Error at %0t: %s reads %0d, expected %0d",
                $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("** Error at %0t: %s is %b, expected %b",
                $time, what, got, exp));
        end
    endtask

    // ====================
    // Stimulus and model
    // ====================
    function automatic logic [15:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    // Table encoder following the standard 8b/10b rules
    function automatic codec_pkg::symbol_t model_encode(input codec_pkg::byte_t b,
                                                        input logic is_k, input logic rd);
        logic [4:0] x;
        logic [2:0] y;
        logic [5:0] c6;
        logic [3:0] c4;
        logic       rd6;
        logic       alt7;
        x = b[4:0];
        y = b[7:5];
        if (is_k && x == 5'd28) begin
            // K28.y at negative disparity is 001111 with its 4b block sent at positive disparity
            c4 = (y == 3'd7) ? 4'b0111 : SUB4[y];
            if ($countones(c4) == 3 || y == 3'd3) begin
                c4 = ~c4;
            end
            return rd ? ~{6'b001111, c4} : {6'b001111, c4};
        end
        c6 = SUB6[x];
        // Heavy codes and D.7 are complemented at positive disparity
        if (rd && ($countones(c6) == 4 || x == 5'd7)) begin
            c6 = ~c6;
        end
        rd6 = ($countones(c6) == 4) ? 1'b1 : ($countones(c6) == 2) ? 1'b0 : rd;
        alt7 = (y == 3'd7) && (is_k || (rd6 ? (x == 5'd11 || x == 5'd13 || x == 5'd14)
                                            : (x == 5'd17 || x == 5'd18 || x == 5'd20)));
        c4 = alt7 ? 4'b0111 : SUB4[y];
        if (rd6 && ($countones(c4) == 3 || y == 3'd3)) begin
            c4 = ~c4;
        end
        return {c6, c4};
    endfunction

    // Six ones leave the line positive and four leave it negative
    function automatic logic disp_after(input codec_pkg::symbol_t s, input logic rd);
        return ($countones(s) == 6) ? 1'b1 : ($countones(s) == 4) ? 1'b0 : rd;
    endfunction

    // ====================
    // APB
    // ====================
    task automatic apb_access(input logic write, input codec_pkg::apb_addr_t addr,
                              input codec_pkg::apb_data_t wdata, input logic exp_err,
                              output codec_pkg::apb_data_t rdata);
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        // Responses are taken at the edge that ends the access cycle
        @(posedge clk);
        rdata = prdata;
        if (pready !== 1'b1) begin
            stop_on_error("pready was not high in the APB access phase");
        end
        check_flag($sformatf("pslverr at address %h", addr), pslverr, exp_err);
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_write(input codec_pkg::apb_addr_t addr, input codec_pkg::apb_data_t data,
                             input logic exp_err);
        codec_pkg::apb_data_t unused;
        apb_access(1'b1, addr, data, exp_err, unused);
    endtask

    task automatic read_check(input string what, input codec_pkg::apb_addr_t addr,
                              input codec_pkg::apb_data_t exp);
        codec_pkg::apb_data_t rdata;
        apb_access(1'b0, addr, '0, 1'b0, rdata);
        check_count(what, rdata, exp);
    endtask

    // ====================
    // Traffic
    // ====================
    // Random bytes through the encoder and back through the loopback
    task automatic run_traffic(input int n_bytes);
        int                 sent;
        logic               tx_due;
        logic               rx_due;
        codec_pkg::symbol_t due_sym;
        codec_pkg::byte_t   b;
        logic               kf;
        logic [8:0]         exp_entry;
        sent = 0;
        tx_due = 1'b0;
        rx_due = 1'b0;
        while (sent < n_bytes || tx_due || rx_due) begin
            @(negedge clk);
            if (tx_due) begin
                if (!tx_symbol_valid) begin
                    stop_on_error("tx_symbol_valid missing one cycle after an accepted byte");
                end
                check_symbol("tx_symbol", tx_symbol, due_sym);
            end else if (tx_symbol_valid) begin
                stop_on_error("tx_symbol_valid came without an accepted byte");
            end
            if (rx_due) begin
                if (!rx_data_valid) begin
                    stop_on_error("rx_data_valid missing two cycles after a tx byte");
                end
                exp_entry = exp_q.pop_front();
                check_byte("rx_data", rx_data, exp_entry[7:0]);
                check_flag("rx_k", rx_k, exp_entry[8]);
                check_flag("rx_disperr", rx_disperr, 1'b0);
                check_flag("rx_notintable", rx_notintable, 1'b0);
            end else if (rx_data_valid) begin
                stop_on_error("rx_data_valid came without a byte in flight");
            end
            rx_due = tx_due;
            tx_due = 1'b0;
            if (sent < n_bytes && next_random() % 4 != 0) begin
                // About one byte in ten is a control character
                kf = (next_random() % 10 == 0);
                b = kf ? K_LIST[next_random() % 12] : codec_pkg::byte_t'(next_random());
                tx_data = b;
                tx_k = kf;
                tx_valid = 1'b1;
                due_sym = model_encode(b, kf, model_rd);
                model_rd = disp_after(due_sym, model_rd);
                exp_q.push_back({kf, b});
                sent++;
                tx_due = 1'b1;
            end else begin
                tx_data = codec_pkg::byte_t'(next_random());
                tx_k = 1'b0;
                tx_valid = 1'b0;
            end
        end
    endtask

    // One symbol straight into the decoder, checked on the next falling edge
    task automatic inject_symbol(input codec_pkg::symbol_t sym, input logic exp_code_err,
                                 input logic exp_disp_err, input logic is_comma);
        inj_symbol = sym;
        inj_valid = 1'b1;
        @(negedge clk);
        inj_valid = 1'b0;
        if (!rx_data_valid) begin
            stop_on_error("rx_data_valid missing one cycle after an injected symbol");
        end
        check_flag("rx_notintable", rx_notintable, exp_code_err);
        check_flag("rx_disperr", rx_disperr, exp_disp_err);
        if (is_comma) begin
            check_byte("rx_data", rx_data, codec_pkg::K28_5);
            check_flag("rx_k", rx_k, 1'b1);
        end
    endtask

    // Both directions disabled while every input keeps toggling
    task automatic run_disabled(input int n_cycles);
        loopback = 1'b0;
        repeat (n_cycles + 1) begin
            @(negedge clk);
            if (tx_symbol_valid || rx_data_valid) begin
                stop_on_error("A valid output came while CTRL had both directions disabled");
            end
            tx_data = codec_pkg::byte_t'(next_random());
            tx_valid = next_random() % 2;
            inj_symbol = codec_pkg::symbol_t'(next_random());
            inj_valid = next_random() % 2;
        end
        tx_valid = 1'b0;
        inj_valid = 1'b0;
        loopback = 1'b1;
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        tx_data = '0;
        tx_k = 1'b0;
        tx_valid = 1'b0;
        inj_symbol = '0;
        inj_valid = 1'b0;
        loopback = 1'b1;
        model_rd = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_flag("tx_symbol_valid after reset", tx_symbol_valid, 1'b0);
        check_flag("rx_data_valid after reset", rx_data_valid, 1'b0);
        check_flag("rx_disperr after reset", rx_disperr, 1'b0);
        check_flag("rx_notintable after reset", rx_notintable, 1'b0);
        check_flag("pslverr after reset", pslverr, 1'b0);

        // Encoding and round trip through the loopback
        run_traffic(N_BYTES);
        // Decoder follows the encoder, so both disparities match the model
        read_check("STATUS", codec_pkg::STATUS_ADDR, {30'd0, model_rd, model_rd});
        read_check("DISPERR_CNT", codec_pkg::DISPERR_CNT_ADDR, 0);
        read_check("CODEERR_CNT", codec_pkg::CODEERR_CNT_ADDR, 0);

        // Symbols outside the code table
        loopback = 1'b0;
        repeat (N_CODE_ERR) begin
            inject_symbol((next_random() % 2 == 0) ? 10'h000 : 10'h3FF, 1'b1, 1'b0, 1'b0);
        end
        read_check("CODEERR_CNT", codec_pkg::CODEERR_CNT_ADDR, N_CODE_ERR);
        read_check("DISPERR_CNT", codec_pkg::DISPERR_CNT_ADDR, 0);

        // Disparity errors, each pair starting from negative disparity
        if (model_rd) begin
            inject_symbol(K28_5_POS, 1'b0, 1'b0, 1'b1);
        end
        repeat (N_DISP_PAIRS) begin
            inject_symbol(K28_5_NEG, 1'b0, 1'b0, 1'b1);
            inject_symbol(K28_5_NEG, 1'b0, 1'b1, 1'b1);
            inject_symbol(K28_5_POS, 1'b0, 1'b0, 1'b1);
        end
        // Line the decoder back up with the encoder before more loopback
        if (model_rd) begin
            inject_symbol(K28_5_NEG, 1'b0, 1'b0, 1'b1);
        end
        loopback = 1'b1;
        read_check("DISPERR_CNT", codec_pkg::DISPERR_CNT_ADDR, N_DISP_PAIRS);

        // Register access
        apb_write(codec_pkg::DISPERR_CNT_ADDR, 32'hFFFF_FFFF, 1'b0);
        read_check("DISPERR_CNT", codec_pkg::DISPERR_CNT_ADDR, 0);
        apb_write(codec_pkg::CODEERR_CNT_ADDR, 32'h0000_0001, 1'b0);
        read_check("CODEERR_CNT", codec_pkg::CODEERR_CNT_ADDR, 0);
        apb_write(codec_pkg::CTRL_ADDR, 32'h0, 1'b0);
        read_check("CTRL", codec_pkg::CTRL_ADDR, 32'h0);
        run_disabled(N_OFF);
        apb_write(codec_pkg::CTRL_ADDR, 32'h3, 1'b0);
        read_check("CTRL", codec_pkg::CTRL_ADDR, 32'h3);
        run_traffic(N_RESUME);
        apb_write(8'h10, 32'h0, 1'b1);
        apb_write(codec_pkg::STATUS_ADDR, 32'h3, 1'b1);
        read_check("STATUS", codec_pkg::STATUS_ADDR, {30'd0, model_rd, model_rd});
        read_check("DISPERR_CNT", codec_pkg::DISPERR_CNT_ADDR, 0);
        read_check("CODEERR_CNT", codec_pkg::CODEERR_CNT_ADDR, 0);
        begin : unmapped_read
            codec_pkg::apb_data_t rdata;
            apb_access(1'b0, 8'h10, '0, 1'b1, rdata);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== source/codec_top.sv ====
// 8b/10b codec top level
module codec_top #(
    parameter int ERR_CNT_W = 16
) (
    input  logic                 clk,
    input  logic                 reset,
    // APB slave
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  codec_pkg::apb_addr_t paddr,
    input  codec_pkg::apb_data_t pwdata,
    output codec_pkg::apb_data_t prdata,
    output logic                 pready,
    output logic                 pslverr,
    // Transmit path
    input  codec_pkg::byte_t     tx_data,
    input  logic                 tx_k,
    input  logic                 tx_valid,
    output codec_pkg::symbol_t   tx_symbol,
    output logic                 tx_symbol_valid,
    // Receive path
    input  codec_pkg::symbol_t   rx_symbol,
    input  logic                 rx_valid,
    output codec_pkg::byte_t     rx_data,
    output logic                 rx_k,
    output logic                 rx_disperr,
    output logic                 rx_notintable,
    output logic                 rx_data_valid
);

    logic enc_enable;
    logic dec_enable;
    logic enc_disp;
    logic dec_disp;
    logic disperr_event;
    logic codeerr_event;

    // Registers steer both directions and count decoder errors
    link_regs #(
        .ERR_CNT_W(ERR_CNT_W)
    ) u_regs (
        .clk          (clk),
        .reset        (reset),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .enc_disp     (enc_disp),
        .dec_disp     (dec_disp),
        .disperr_event(disperr_event),
        .codeerr_event(codeerr_event),
        .enc_enable   (enc_enable),
        .dec_enable   (dec_enable)
    );

    enc_8b10b u_enc (
        .clk         (clk),
        .reset       (reset),
        .enable      (enc_enable),
        .data        (tx_data),
        .k           (tx_k),
        .valid       (tx_valid),
        .symbol      (tx_symbol),
        .symbol_valid(tx_symbol_valid),
        .disp        (enc_disp)
    );

    dec_8b10b u_dec (
        .clk          (clk),
        .reset        (reset),
        .enable       (dec_enable),
        .symbol       (rx_symbol),
        .valid        (rx_valid),
        .data         (rx_data),
        .k            (rx_k),
        .disperr      (rx_disperr),
        .notintable   (rx_notintable),
        .data_valid   (rx_data_valid),
        .disp         (dec_disp),
        .disperr_event(disperr_event),
        .codeerr_event(codeerr_event)
    );

endmodule

// ==== source/link_regs.sv ====
// APB control and status registers
module link_regs #(
    parameter int ERR_CNT_W = 16
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  codec_pkg::apb_addr_t paddr,
    input  codec_pkg::apb_data_t pwdata,
    output codec_pkg::apb_data_t prdata,
    output logic                 pready,
    output logic                 pslverr,
    input  logic                 enc_disp,
    input  logic                 dec_disp,
    input  logic                 disperr_event,
    input  logic                 codeerr_event,
    output logic                 enc_enable,
    output logic                 dec_enable
);

    logic                 access;
    logic                 wr;
    logic                 sel_ctrl;
    logic                 sel_status;
    logic                 sel_derr;
    logic                 sel_cerr;
    logic [1:0]           ctrl;
    // Index 0 counts disparity errors and index 1 code errors
    logic [1:0]           events;
    logic [1:0]           clear;
    logic [ERR_CNT_W-1:0] err_cnt [2];

    // ====================
    // Access decode
    // ====================
    // Transfers complete in the access phase since there are no wait states
    assign access = psel && penable;
    assign wr = access && pwrite;
    assign pready = 1'b1;

    assign sel_ctrl = paddr == codec_pkg::CTRL_ADDR;
    assign sel_status = paddr == codec_pkg::STATUS_ADDR;
    assign sel_derr = paddr == codec_pkg::DISPERR_CNT_ADDR;
    assign sel_cerr = paddr == codec_pkg::CODEERR_CNT_ADDR;

    // Unmapped addresses and writes to the read-only status fail
    assign pslverr = access && (!(sel_ctrl || sel_status || sel_derr || sel_cerr)
        || (pwrite && sel_status));

    // Both directions run after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl <= 2'b11;
        end else if (wr && sel_ctrl) begin
            ctrl <= pwdata[1:0];
        end
    end

    assign enc_enable = ctrl[0];
    assign dec_enable = ctrl[1];

    // ====================
    // Error counters
    // ====================
    assign events = {codeerr_event, disperr_event};
    assign clear = {wr && sel_cerr, wr && sel_derr};

    // A write wins over an event in the same cycle, and a full counter holds
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (reset || clear[i]) begin
                err_cnt[i] <= '0;
            end else if (events[i] && err_cnt[i] != '1) begin
                err_cnt[i] <= err_cnt[i] + 1'b1;
            end
        end
    end

    // Read data, with the counters zero-extended
    always_comb begin
        case (paddr)
            codec_pkg::CTRL_ADDR:        prdata = codec_pkg::apb_data_t'(ctrl);
            codec_pkg::STATUS_ADDR:      prdata = codec_pkg::apb_data_t'({dec_disp, enc_disp});
            codec_pkg::DISPERR_CNT_ADDR: prdata = codec_pkg::apb_data_t'(err_cnt[0]);
            codec_pkg::CODEERR_CNT_ADDR: prdata = codec_pkg::apb_data_t'(err_cnt[1]);
            default:                     prdata = '0;
        endcase
    end

    // The access phase always follows a select
    assert property (@(posedge clk) disable iff (reset)
        penable |-> psel);

endmodule

// ==== source/dec_8b10b.sv ====
// 8b/10b decoder
module dec_8b10b (
    input  logic               clk,
    input  logic               reset,
    input  logic               enable,
    input  codec_pkg::symbol_t symbol,
    input  logic               valid,
    output codec_pkg::byte_t   data,
    output logic               k,
    output logic               disperr,
    output logic               notintable,
    output logic               data_valid,
    output logic               disp,
    output logic               disperr_event,
    output logic               codeerr_event
);

    logic [5:0] s6;
    logic [3:0] s4;
    // The 4b block with K28 at positive disparity turned back to data form
    logic [3:0] s4_d;
    logic       accept;
    logic       k28;
    logic       hit6;
    logic       hit4;
    logic [4:0] x;
    logic [2:0] y;
    logic       alt;
    logic       k_dec;
    logic       neg6;
    logic       pos6;
    logic       neg4;
    logic       pos4;
    logic       disp_mid;
    logic       disp_end;
    logic       bad_code;
    logic       bad_disp;

    assign s6 = symbol[9:4];
    assign s4 = symbol[3:0];
    assign accept = valid && enable;

    // ====================
    // Inverse tables
    // ====================
    always_comb begin
        k28 = (s6 == codec_pkg::K28_6B) || (s6 == ~codec_pkg::K28_6B);
        hit6 = k28;
        x = 5'd28;
        // Inverted forms count only where the encoder inverts
        for (int i = 0; i < 32; i++) begin
            if (s6 == codec_pkg::CODE_6B[i] || (s6 == ~codec_pkg::CODE_6B[i]
                    && ($countones(codec_pkg::CODE_6B[i]) != 3 || i == 7))) begin
                hit6 = 1'b1;
                x = 5'(i);
            end
        end

        s4_d = (s6 == ~codec_pkg::K28_6B) ? ~s4 : s4;
        hit4 = 1'b0;
        y = 3'd0;
        alt = 1'b0;
        for (int j = 0; j < 8; j++) begin
            if (s4_d == codec_pkg::CODE_4B[j] || (s4_d == ~codec_pkg::CODE_4B[j]
                    && ($countones(codec_pkg::CODE_4B[j]) != 2 || j == 3))) begin
                hit4 = 1'b1;
                y = 3'(j);
            end
        end
        if (s4_d == codec_pkg::CODE_4B_A7 || s4_d == ~codec_pkg::CODE_4B_A7) begin
            hit4 = 1'b1;
            y = 3'd7;
            alt = 1'b1;
        end

        // Alternate x.7 on these four is the only way to reach K23/27/29/30.7
        k_dec = k28 || (alt && (x == 5'd23 || x == 5'd27 || x == 5'd29 || x == 5'd30));

        // ====================
        // Disparity rules
        // ====================
        // Heavy blocks and the restricted neutral codes need negative disparity on entry
        neg6 = $countones(s6) == 4 || s6 == codec_pkg::CODE_6B[7];
        pos6 = $countones(s6) == 2 || s6 == ~codec_pkg::CODE_6B[7];
        neg4 = $countones(s4) == 3 || s4 == codec_pkg::CODE_4B[3];
        pos4 = $countones(s4) == 1 || s4 == ~codec_pkg::CODE_4B[3];
        // A restricted block fixes the disparity it leaves behind
        disp_mid = (neg6 || pos6) ? ($countones(s6) == 4 || s6 == ~codec_pkg::CODE_6B[7]) : disp;
        disp_end = (neg4 || pos4) ? ($countones(s4) == 3 || s4 == ~codec_pkg::CODE_4B[3])
                                  : disp_mid;

        // Two restricted blocks that disagree can never occur in any disparity
        bad_code = !hit6 || !hit4
            || ((neg6 || pos6) && ((neg4 && disp_mid) || (pos4 && !disp_mid)))
            || (y == 3'd7 && !k_dec && alt != codec_pkg::use_alt7(x, disp_mid))
            || (k28 && y == 3'd7 && !alt);
        bad_disp = (neg6 && disp) || (pos6 && !disp)
            || (!(neg6 || pos6) && ((neg4 && disp_mid) || (pos4 && !disp_mid)));
    end

    // ====================
    // Output registers
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            data_valid <= 1'b0;
            disperr <= 1'b0;
            notintable <= 1'b0;
            disp <= 1'b0;
        end else begin
            data_valid <= accept;
            if (accept) begin
                notintable <= bad_code;
                disperr <= bad_disp && !bad_code;
                // A valid symbol resynchronizes the disparity, an unknown one is ignored
                if (!bad_code) begin
                    disp <= disp_end;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            data <= {y, x};
            k <= k_dec;
        end
    end

    // Error pulses for the counters, one per decoded symbol
    assign disperr_event = data_valid && disperr;
    assign codeerr_event = data_valid && notintable;

    // A symbol is either outside the table or checked for disparity, never both
    assert property (@(posedge clk) disable iff (reset)
        !(disperr && notintable));

endmodule

// ==== source/enc_8b10b.sv ====
// 8b/10b encoder
module enc_8b10b (
    input  logic               clk,
    input  logic               reset,
    input  logic               enable,
    input  codec_pkg::byte_t   data,
    input  logic               k,
    input  logic               valid,
    output codec_pkg::symbol_t symbol,
    output logic               symbol_valid,
    output logic               disp
);

    // Byte split into EDCBA and HGF
    logic [4:0] x;
    logic [2:0] y;
    logic       accept;
    logic       k28;
    logic [5:0] c6;
    logic [5:0] s6;
    logic       disp_mid;
    logic       use_a7;
    logic       flip4;
    logic [3:0] c4;
    logic [3:0] s4;
    logic       disp_next;

    assign x = data[4:0];
    assign y = data[7:5];
    assign accept = valid && enable;
    assign k28 = k && (x == codec_pkg::K28_5[4:0]);

    // ====================
    // Sub-block coding
    // ====================
    always_comb begin
        c6 = k28 ? codec_pkg::K28_6B : codec_pkg::CODE_6B[x];
        // Unbalanced codes and D.7 are sent inverted at positive disparity
        s6 = (disp && ($countones(c6) != 3 || c6 == codec_pkg::CODE_6B[7])) ? ~c6 : c6;
        // Only an unbalanced 6b block moves the disparity
        disp_mid = ($countones(c6) != 3) ? !disp : disp;

        // Every control character ending in x.7 uses the alternate form
        use_a7 = (y == 3'd7) && (k || codec_pkg::use_alt7(x, disp_mid));
        c4 = use_a7 ? codec_pkg::CODE_4B_A7 : codec_pkg::CODE_4B[y];

        // The 4b block follows the disparity left by the 6b block
        flip4 = disp_mid && ($countones(c4) != 2 || c4 == codec_pkg::CODE_4B[3]);
        // K28 at positive disparity is the complement of its negative form,
        // so its balanced 4b codes are inverted as well
        if (k28 && disp && $countones(c4) == 2 && c4 != codec_pkg::CODE_4B[3]) begin
            flip4 = 1'b1;
        end
        s4 = flip4 ? ~c4 : c4;
        disp_next = ($countones(c4) != 2) ? !disp_mid : disp_mid;
    end

    // ====================
    // Output registers
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            symbol_valid <= 1'b0;
            disp <= 1'b0;
        end else begin
            symbol_valid <= accept;
            // Disparity moves only on accepted bytes
            if (accept) begin
                disp <= disp_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            symbol <= {s6, s4};
        end
    end

    // A coded symbol never strays more than one step from balance
    assert property (@(posedge clk) disable iff (reset)
        symbol_valid |-> $countones(symbol) inside {4, 5, 6});

    // Only K28.y, K23.7, K27.7, K29.7 and K30.7 exist as control characters
    assert property (@(posedge clk) disable iff (reset)
        valid && k |-> k28 || data inside {8'hF7, 8'hFB, 8'hFD, 8'hFE});

endmodule

// ==== common/codec_pkg.sv ====
// 8b/10b codec shared definitions
package codec_pkg;

    // Widths that carry a meaning on the link and on the register bus
    typedef logic [7:0] byte_t;
    // Line symbol abcdei fghj, bit a sits at bit 9 and bit j at bit 0
    typedef logic [9:0] symbol_t;
    typedef logic [7:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // ====================
    // Register map
    // ====================
    localparam apb_addr_t CTRL_ADDR        = 8'h00;
    localparam apb_addr_t STATUS_ADDR      = 8'h04;
    localparam apb_addr_t DISPERR_CNT_ADDR = 8'h08;
    localparam apb_addr_t CODEERR_CNT_ADDR = 8'h0C;

    // ====================
    // Code tables
    // ====================
    // Comma character K28.5
    localparam byte_t K28_5 = 8'hBC;

    // 5b/6b codes abcdei as sent at negative running disparity, indexed by EDCBA
    localparam logic [5:0] CODE_6B [32] = '{
        6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
        6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
        6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
        6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
    };
    // K28 uses its own 6b block, which contains the comma run
    localparam logic [5:0] K28_6B = 6'b001111;

    // 3b/4b codes fghj at negative running disparity, indexed by HGF
    localparam logic [3:0] CODE_4B [8] = '{
        4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
    };
    // Alternate form of x.7
    localparam logic [3:0] CODE_4B_A7 = 4'b0111;

    // D.x.7 takes the alternate form where the primary one would make a run of five
    function automatic logic use_alt7(logic [4:0] x, logic rd);
        return rd ? (x == 5'd11 || x == 5'd13 || x == 5'd14)
                  : (x == 5'd17 || x == 5'd18 || x == 5'd20);
    endfunction

endpackage
